// File: lock_top.f
logic/lock_pkg.sv
logic/tone_pkg.sv
logic/key_if.sv
logic/keypad_decoder.sv
logic/code_entry_fsm.sv
logic/lockout_timer.sv
logic/buzzer_sequencer.sv
logic/lock_top.sv
tb/lock_asserts.sv
tb/lock_tb.sv

// File: Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := lock_tb
FILELIST  := lock_top.f
OBJ_DIR   := obj_dir
PASS_MSG  := PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulation passes only if the pass line shows up in its output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb/lock_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lock_tb import lock_pkg::*; ();

    localparam logic [11:0] SECRET_CODE   = 12'h246;
    localparam int          MAX_TRIES     = 3;
    localparam int          TICKS_PER_SEC = 20;
    localparam int          LOCK_SECONDS  = 5;
    localparam int          TONE_UNIT     = 1;
    localparam int          IDLE_CYCLES   = 150;
    localparam int          HOLD_LONG     = 40;
    localparam int          N_RANDOM      = 24;
    localparam int          N_MULTI       = 4;
    localparam int          CLICK_CYCLES  = 40 * TONE_UNIT;
    localparam int          TUNE_CYCLES   = 120 * TONE_UNIT;   // success and fail
    localparam int          ENTER_LINE    = 0;
    localparam int          RESET_LINE    = 8;
    localparam int          CLEAR_LINE    = 12;
    localparam int          NUM_PRESSES   = N_RANDOM + 1 + 3 + 5 + 4 * MAX_TRIES + N_MULTI + 2;
    localparam int          TIMEOUT_CYCLES = NUM_PRESSES * 160 + MAX_TRIES * 110 + HOLD_LONG + 20;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [15:0] onehot;
    logic [11:0] display;
    logic [1:0]  tries;
    logic        unlocked;
    logic        locked;
    logic        buzzer;

    logic [31:0] lfsr_q;
    lock_state_e m_state;
    logic [11:0] m_disp;
    int          m_cnt;
    int          m_tries;
    int          cycle_cnt = 0;

    lock_top #(
        .SECRET_CODE   (SECRET_CODE),
        .MAX_TRIES     (MAX_TRIES),
        .TICKS_PER_SEC (TICKS_PER_SEC),
        .LOCK_SECONDS  (LOCK_SECONDS),
        .TONE_UNIT     (TONE_UNIT)
    ) uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .onehot   (onehot),
        .display  (display),
        .tries    (tries),
        .unlocked (unlocked),
        .locked   (locked),
        .buzzer   (buzzer)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic int rand_bits(input int n);
        int r;
        r = 0;
        for (int b = 0; b < n; b++) begin
            r = (r << 1) | int'(lfsr_q[0]);
            lfsr_q = lfsr_step(lfsr_q);   // one step per bit
        end
        return r;
    endfunction

    function automatic int line_of_digit(input logic [3:0] d);
        for (int i = 0; i < 16; i++) begin
            if (KEY_MAP[i][5:4] == KEY_DIGIT && KEY_MAP[i][3:0] == d) begin
                return i;
            end
        end
        return 1;
    endfunction

    function automatic int random_digit_line();
        int ln;
        ln = rand_bits(4);
        while (KEY_MAP[ln][5:4] != KEY_DIGIT) begin
            ln = rand_bits(4);
        end
        return ln;
    endfunction

    function automatic int line_of_mask(input logic [15:0] mask);
        for (int i = 0; i < 16; i++) begin
            if (mask[i]) begin
                return i;
            end
        end
        return 0;
    endfunction

    function automatic logic [7:0] bcd_of(input int v);
        return {4'(v / 10), 4'(v % 10)};
    endfunction

    // expected reaction to one key event
    function automatic void model_key(input int line, output logic beep, output int len);
        key_op_e    op;
        logic [3:0] dg;
        op   = key_op_e'(KEY_MAP[line][5:4]);
        dg   = KEY_MAP[line][3:0];
        beep = 1'b0;
        len  = 0;
        if (m_state == ST_ENTRY) begin
            if (op == KEY_DIGIT) begin
                if (m_cnt < 3) begin
                    m_disp = {m_disp[7:0], dg};
                    m_cnt++;
                end
                beep = 1'b1;
                len  = CLICK_CYCLES;
            end else if (op == KEY_CLEAR || op == KEY_RESET) begin
                m_disp = BLANK_DISPLAY;
                m_cnt  = 0;
                if (op == KEY_RESET) m_tries = 0;
            end else if (m_cnt == 3) begin   // enter with a full code
                beep  = 1'b1;
                len   = TUNE_CYCLES;
                m_cnt = 0;
                if (m_disp == SECRET_CODE) begin
                    m_state = ST_OPEN;
                    m_disp  = PASS_PATTERN;
                end else begin
                    m_disp = BLANK_DISPLAY;
                    if (m_tries + 1 >= MAX_TRIES) begin
                        m_state = ST_LOCKED;
                        m_tries = 0;
                    end else begin
                        m_tries++;
                    end
                end
            end
        end else if (m_state == ST_OPEN && (op == KEY_RESET || op == KEY_CLEAR)) begin
            m_state = ST_ENTRY;
            m_disp  = BLANK_DISPLAY;
            m_cnt   = 0;
            if (op == KEY_RESET) m_tries = 0;
        end
    endfunction

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %s expected %0h actual %0h", name, exp, act);
            $display("FAIL: see errors above");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("ERROR: %s", why);
        $display("FAIL: see errors above");
        $fatal(1, "run aborted");
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic check_outputs(input string name);
        check_eq({name, " tries"}, m_tries, 32'(tries));
        check_eq({name, " unlocked"}, 32'(m_state == ST_OPEN), 32'(unlocked));
        check_eq({name, " locked"}, 32'(m_state == ST_LOCKED), 32'(locked));
        if (m_state == ST_LOCKED) begin
            check_eq({name, " display"}, 4'hF, 32'(display[11:8]));
        end else begin
            check_eq({name, " display"}, m_disp, display);
        end
    endtask

    task automatic press_mask(input logic [15:0] mask, input int hold, input string name);
        logic        beep;
        logic        locking;
        logic [11:0] old_disp;
        int          len;
        int          rise_at;
        int          last_high;
        int          last;
        beep      = 1'b0;
        len       = 0;
        rise_at   = -1;
        last_high = -1;
        old_disp  = m_disp;
        locking   = (m_state != ST_LOCKED);
        if ($countones(mask) == 1) model_key(line_of_mask(mask), beep, len);
        locking = locking && (m_state == ST_LOCKED);
        last    = locking ? 3 : hold + IDLE_CYCLES;   // lockout runs on its own
        onehot  = mask;
        for (int i = 1; i <= last; i++) begin
            tick();
            if (i == hold) onehot = 16'h0000;
            if (i == 2) check_eq({name, " early display"}, old_disp, display);
            if (i == 3) check_outputs(name);
            if (buzzer) begin
                if (rise_at < 0) rise_at = i;
                last_high = i;
            end
        end
        if (!locking) begin
            check_outputs({name, " settled"});
            if (beep) begin
                check_eq({name, " buzzer on"}, 1, 32'(rise_at >= 4 && rise_at <= 5));
                check_eq({name, " buzzer off"}, 1, 32'(last_high < rise_at + len + 4));
            end else begin
                check_eq({name, " buzzer quiet"}, -1, rise_at);
            end
        end
    endtask

    task automatic press_line(input int line, input string name);
        press_mask(16'd1 << line, 2, name);
    endtask

    task automatic run_lockout();
        int n;
        int secs;
        int limit;
        n     = 0;
        limit = LOCK_SECONDS * TICKS_PER_SEC + 3;   // timer load, lockout, done pulse, exit
        check_eq("lockout entered", 1, 32'(locked));
        while (locked) begin
            tick();
            n++;
            case (n)
                10: onehot = 16'd1 << line_of_digit(4'd7);
                40: onehot = 16'd1 << ENTER_LINE;
                70: onehot = 16'd1 << RESET_LINE;
                12, 42, 72: onehot = 16'h0000;
                default: ;
            endcase
            if (locked) begin
                secs = LOCK_SECONDS - (n - 1) / TICKS_PER_SEC;
                check_eq("lockout display", {4'hF, bcd_of(secs)}, display);
                check_eq("lockout tries", 0, 32'(tries));
                check_eq("lockout unlocked", 0, 32'(unlocked));
            end
            if (n > limit) abort_run("lockout did not end in time");
        end
        check_eq("lockout length", limit, n);
        m_state = ST_ENTRY;   // keys during the lockout were dropped
        m_disp  = BLANK_DISPLAY;
        m_cnt   = 0;
        m_tries = 0;
        check_outputs("after lockout");
        repeat (40) tick();   // fail tone runs out
    endtask

    initial begin
        logic [3:0] d0;
        logic [3:0] d1;
        logic [3:0] d2;
        int         a;
        int         b;
        rst_n   = 1'b0;
        onehot  = 16'h0000;
        lfsr_q  = 32'h3157c186;
        m_state = ST_ENTRY;
        m_disp  = BLANK_DISPLAY;
        m_cnt   = 0;
        m_tries = 0;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;
        check_outputs("after reset");

        for (int k = 0; k < N_RANDOM; k++) begin
            if (rand_bits(3) == 0) press_line(CLEAR_LINE, "random clear");
            else press_line(random_digit_line(), "random digit");
        end
        press_line(CLEAR_LINE, "clear");

        press_line(random_digit_line(), "short digit");
        press_line(ENTER_LINE, "short enter");   // no tone expected
        press_line(CLEAR_LINE, "short clear");

        press_line(line_of_digit(SECRET_CODE[11:8]), "code digit");
        press_line(line_of_digit(SECRET_CODE[7:4]), "code digit");
        press_line(line_of_digit(SECRET_CODE[3:0]), "code digit");
        press_line(ENTER_LINE, "code enter");
        press_line(RESET_LINE, "open reset");

        for (int t = 0; t < MAX_TRIES; t++) begin
            d0 = 4'(rand_bits(4) % 10);
            d1 = 4'(rand_bits(4) % 10);
            d2 = 4'(rand_bits(4) % 10);
            if ({d0, d1, d2} == SECRET_CODE) d2 = 4'((d2 + 1) % 10);
            press_line(line_of_digit(d0), "wrong digit");
            press_line(line_of_digit(d1), "wrong digit");
            press_line(line_of_digit(d2), "wrong digit");
            press_line(ENTER_LINE, "wrong enter");
        end
        run_lockout();

        for (int k = 0; k < N_MULTI; k++) begin
            a = rand_bits(4);
            b = a ^ (rand_bits(4) | 1);   // always a second line
            press_mask((16'd1 << a) | (16'd1 << b), 2, "multi-hot");
        end
        press_mask(16'd1 << line_of_digit(4'd5), HOLD_LONG, "held key");
        press_line(CLEAR_LINE, "clear after hold");

        if (uut.u_asserts.fail_cnt == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("ERROR: %0d assertion failures", uut.u_asserts.fail_cnt);
            $display("FAIL: see errors above");
            $fatal(1, "assertions failed");
        end
    end

endmodule

`default_nettype wire

// File: tb/lock_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module lock_asserts import tone_pkg::*; #(
    parameter int TONE_UNIT = 1
) (
    input logic clk,
    input logic rst_n,
    input logic key_req,
    input logic key_ack,
    input logic tone_req,
    input logic tone_ack,
    input logic buzzer
);

    // longest pattern in clock cycles
    localparam int PATTERN_MAX = TONE_UNIT * ((SUCCESS_LEN > FAIL_LEN) ? SUCCESS_LEN : FAIL_LEN);

    int fail_cnt = 0;   // failures seen so far
    int since_start;    // cycles since the sequencer took a request

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            since_start <= PATTERN_MAX;
        end else if (tone_req && !tone_ack) begin
            since_start <= 0;
        end else if (since_start < PATTERN_MAX) begin
            since_start <= since_start + 1;
        end
    end

    key_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        key_req && !key_ack |=> key_req)
        else begin
            $error("key req dropped before ack");
            fail_cnt++;
        end

    key_ack_held: assert property (@(posedge clk) disable iff (!rst_n)
        key_ack && key_req |=> key_ack)
        else begin
            $error("key ack dropped while req high");
            fail_cnt++;
        end

    key_req_start: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(key_req) |-> !key_ack)
        else begin
            $error("key req raised with ack still high");
            fail_cnt++;
        end

    key_ack_start: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(key_ack) |-> key_req)
        else begin
            $error("key ack raised without req");
            fail_cnt++;
        end

    tone_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        tone_req && !tone_ack |=> tone_req)
        else begin
            $error("tone req dropped before ack");
            fail_cnt++;
        end

    tone_ack_held: assert property (@(posedge clk) disable iff (!rst_n)
        tone_ack && tone_req |=> tone_ack)
        else begin
            $error("tone ack dropped while req high");
            fail_cnt++;
        end

    tone_req_start: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(tone_req) |-> !tone_ack)
        else begin
            $error("tone req raised with ack still high");
            fail_cnt++;
        end

    // sequencer answers in the next cycle
    tone_ack_next: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(tone_req) |=> tone_ack)
        else begin
            $error("tone ack late");
            fail_cnt++;
        end

    // no sound once the longest pattern has run out
    buzzer_idle: assert property (@(posedge clk) disable iff (!rst_n)
        buzzer |-> since_start < PATTERN_MAX)
        else begin
            $error("buzzer high with no pattern playing");
            fail_cnt++;
        end

endmodule

bind lock_top lock_asserts #(
    .TONE_UNIT (TONE_UNIT)
) u_asserts (
    .clk      (clk),
    .rst_n    (rst_n),
    .key_req  (key.req),
    .key_ack  (key.ack),
    .tone_req (tone_req),
    .tone_ack (tone_ack),
    .buzzer   (buzzer)
);

`default_nettype wire

// File: logic/lock_top.sv
`timescale 1ns/1ps
`default_nettype none

module lock_top import tone_pkg::*; #(
    parameter logic [11:0] SECRET_CODE   = 12'h246,
    parameter int          MAX_TRIES     = 3,
    parameter int          TICKS_PER_SEC = 50_000_000,
    parameter int          LOCK_SECONDS  = 60,
    parameter int          TONE_UNIT     = 25_000
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [15:0] onehot,
    output logic [11:0] display,
    output logic [1:0]  tries,
    output logic        unlocked,
    output logic        locked,
    output logic        buzzer
);

    logic       lock_start;
    logic       lock_done;
    logic [7:0] seconds_bcd;
    logic       tone_req;
    logic       tone_ack;
    tone_e      tone_sel;

    key_if key ();

    keypad_decoder u_decoder (
        .clk    (clk),
        .rst_n  (rst_n),
        .onehot (onehot),
        .key    (key.source)
    );

    code_entry_fsm #(
        .SECRET_CODE (SECRET_CODE),
        .MAX_TRIES   (MAX_TRIES)
    ) u_entry (
        .clk         (clk),
        .rst_n       (rst_n),
        .key         (key.sink),
        .lock_start  (lock_start),
        .lock_done   (lock_done),
        .seconds_bcd (seconds_bcd),
        .tone_req    (tone_req),
        .tone_ack    (tone_ack),
        .tone_sel    (tone_sel),
        .display     (display),
        .tries       (tries),
        .unlocked    (unlocked),
        .locked      (locked)
    );

    lockout_timer #(
        .TICKS_PER_SEC (TICKS_PER_SEC),
        .LOCK_SECONDS  (LOCK_SECONDS)
    ) u_timer (
        .clk         (clk),
        .rst_n       (rst_n),
        .lock_start  (lock_start),
        .seconds_bcd (seconds_bcd),
        .lock_done   (lock_done)
    );

    buzzer_sequencer #(
        .TONE_UNIT (TONE_UNIT)
    ) u_buzzer (
        .clk      (clk),
        .rst_n    (rst_n),
        .tone_req (tone_req),
        .tone_sel (tone_sel),
        .tone_ack (tone_ack),
        .buzzer   (buzzer)
    );

endmodule

`default_nettype wire

// File: logic/buzzer_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module buzzer_sequencer import tone_pkg::*; #(
    parameter int TONE_UNIT = 25_000
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  tone_req,
    input  tone_e tone_sel,
    output logic  tone_ack,
    output logic  buzzer
);

    localparam int PW = (TONE_UNIT > 1) ? $clog2(TONE_UNIT) : 1;

    tone_e         sel_q;
    logic          playing;
    logic          wave_q;
    logic [PW-1:0] presc;
    logic          unit_tick;
    logic [6:0]    unit_cnt;   // units elapsed in the pattern
    logic [2:0]    half_cnt;
    logic [2:0]    half_units;
    logic [6:0]    len_units;
    logic          in_gap;

    assign unit_tick  = (presc == PW'(TONE_UNIT - 1));
    assign half_units = 3'(tone_half(sel_q));
    assign len_units  = 7'(tone_len(sel_q));
    assign in_gap     = (sel_q == TONE_FAIL) &&
                        (unit_cnt >= 7'(FAIL_GAP_START)) &&
                        (unit_cnt < 7'(FAIL_GAP_END));

    assign buzzer = playing && wave_q && !in_gap;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tone_ack <= 1'b0;
            sel_q    <= TONE_CLICK;
            playing  <= 1'b0;
            wave_q   <= 1'b0;
            presc    <= '0;
            unit_cnt <= 7'd0;
            half_cnt <= 3'd0;
        end else begin
            if (tone_ack && !tone_req) begin
                tone_ack <= 1'b0;
            end
            if (tone_req && !tone_ack) begin
                tone_ack <= 1'b1;   // restart, even mid-pattern
                sel_q    <= tone_sel;
                playing  <= 1'b1;
                wave_q   <= 1'b1;
                presc    <= '0;
                unit_cnt <= 7'd0;
                half_cnt <= 3'd0;
            end else if (playing) begin
                if (unit_tick) begin
                    presc    <= '0;
                    unit_cnt <= unit_cnt + 7'd1;
                    if (half_cnt == half_units - 3'd1) begin
                        half_cnt <= 3'd0;
                        wave_q   <= ~wave_q;
                    end else begin
                        half_cnt <= half_cnt + 3'd1;
                    end
                    if (unit_cnt == len_units - 7'd1) begin
                        playing <= 1'b0;   // pattern finished
                        wave_q  <= 1'b0;
                    end
                end else begin
                    presc <= presc + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/lockout_timer.sv
`timescale 1ns/1ps
`default_nettype none

module lockout_timer #(
    parameter int TICKS_PER_SEC = 50_000_000,
    parameter int LOCK_SECONDS  = 60
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       lock_start,
    output logic [7:0] seconds_bcd,
    output logic       lock_done
);

    localparam int         PW        = (TICKS_PER_SEC > 1) ? $clog2(TICKS_PER_SEC) : 1;
    localparam logic [7:0] START_BCD = {4'(LOCK_SECONDS / 10), 4'(LOCK_SECONDS % 10)};

    logic          active;
    logic [PW-1:0] presc;
    logic          sec_tick;

    assign sec_tick = (presc == PW'(TICKS_PER_SEC - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active      <= 1'b0;
            presc       <= '0;
            seconds_bcd <= 8'h00;
            lock_done   <= 1'b0;
        end else begin
            lock_done <= 1'b0;
            if (lock_start) begin
                active      <= 1'b1;
                presc       <= '0;
                seconds_bcd <= START_BCD;
            end else if (active) begin
                if (seconds_bcd == 8'h00) begin
                    active    <= 1'b0;   // one cycle after reaching zero
                    lock_done <= 1'b1;
                end else if (sec_tick) begin
                    presc <= '0;
                    if (seconds_bcd[3:0] == 4'd0) begin
                        seconds_bcd <= {seconds_bcd[7:4] - 4'd1, 4'd9};   // borrow from tens
                    end else begin
                        seconds_bcd <= {seconds_bcd[7:4], seconds_bcd[3:0] - 4'd1};
                    end
                end else begin
                    presc <= presc + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/code_entry_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module code_entry_fsm import lock_pkg::*, tone_pkg::*; #(
    parameter logic [11:0] SECRET_CODE = 12'h246,
    parameter int          MAX_TRIES   = 3
) (
    input  logic        clk,
    input  logic        rst_n,
    key_if.sink         key,
    output logic        lock_start,
    input  logic        lock_done,
    input  logic [7:0]  seconds_bcd,
    output logic        tone_req,
    input  logic        tone_ack,
    output tone_e       tone_sel,
    output logic [11:0] display,
    output logic [1:0]  tries,
    output logic        unlocked,
    output logic        locked
);

    lock_state_e state;
    logic [11:0] entry_q;
    logic [1:0]  count_q;
    logic        take;
    logic        full;
    logic        last_try;

    // a pending tone request holds off the next key
    assign take     = key.req && !key.ack && !tone_req && !tone_ack;
    assign full     = (count_q == 2'(CODE_DIGITS));
    assign last_try = (int'(tries) + 1 >= MAX_TRIES);

    assign display  = (state == ST_LOCKED) ? {BLANK_NIBBLE, seconds_bcd} : entry_q;
    assign unlocked = (state == ST_OPEN);
    assign locked   = (state == ST_LOCKED);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_ENTRY;
            entry_q    <= BLANK_DISPLAY;
            count_q    <= 2'd0;
            tries      <= 2'd0;
            key.ack    <= 1'b0;
            tone_req   <= 1'b0;
            tone_sel   <= TONE_CLICK;
            lock_start <= 1'b0;
        end else begin
            lock_start <= 1'b0;
            if (key.ack && !key.req) begin
                key.ack <= 1'b0;
            end
            if (tone_req && tone_ack) begin
                tone_req <= 1'b0;
            end
            if (state == ST_LOCKED && lock_done) begin
                state <= ST_ENTRY;   // lockout over
            end
            if (take) begin
                key.ack <= 1'b1;
                case (state)
                    ST_ENTRY: begin
                        case (key.op)
                            KEY_DIGIT: begin
                                if (!full) begin
                                    entry_q <= {entry_q[7:0], key.digit};
                                    count_q <= count_q + 2'd1;
                                end
                                tone_req <= 1'b1;
                                tone_sel <= TONE_CLICK;
                            end
                            KEY_CLEAR: begin
                                entry_q <= BLANK_DISPLAY;
                                count_q <= 2'd0;
                            end
                            KEY_RESET: begin
                                entry_q <= BLANK_DISPLAY;
                                count_q <= 2'd0;
                                tries   <= 2'd0;
                            end
                            KEY_ENTER: begin
                                if (full && entry_q == SECRET_CODE) begin
                                    state    <= ST_OPEN;
                                    entry_q  <= PASS_PATTERN;
                                    count_q  <= 2'd0;
                                    tone_req <= 1'b1;
                                    tone_sel <= TONE_SUCCESS;
                                end else if (full) begin
                                    entry_q  <= BLANK_DISPLAY;
                                    count_q  <= 2'd0;
                                    tone_req <= 1'b1;
                                    tone_sel <= TONE_FAIL;
                                    if (last_try) begin
                                        state      <= ST_LOCKED;
                                        lock_start <= 1'b1;
                                        tries      <= 2'd0;
                                    end else begin
                                        tries <= tries + 2'd1;
                                    end
                                end
                            end
                            default: ;
                        endcase
                    end
                    ST_OPEN: begin
                        if (key.op == KEY_RESET || key.op == KEY_CLEAR) begin
                            state   <= ST_ENTRY;
                            entry_q <= BLANK_DISPLAY;
                            count_q <= 2'd0;
                        end
                        if (key.op == KEY_RESET) begin
                            tries <= 2'd0;
                        end
                    end
                    default: ;   // locked, key swallowed
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/keypad_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module keypad_decoder import lock_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [15:0] onehot,
    key_if.source       key
);

    logic [15:0] keys_q;
    logic [15:0] prev_q;
    logic        single;
    logic        fresh;
    logic        busy;
    logic [3:0]  line;
    logic [5:0]  entry;

    assign single = (keys_q != 16'h0000) && ((keys_q & (keys_q - 16'd1)) == 16'h0000);
    assign fresh  = (keys_q != prev_q);   // edge on the key vector
    assign busy   = key.req || key.ack;   // handshake still running

    always_comb begin
        line = 4'd0;
        for (int i = 0; i < 16; i++) begin
            if (keys_q[i]) begin
                line = 4'(i);
            end
        end
    end

    assign entry = KEY_MAP[line];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            keys_q  <= 16'h0000;
            prev_q  <= 16'h0000;
            key.req <= 1'b0;
        end else begin
            keys_q <= onehot;
            prev_q <= keys_q;
            if (key.req && key.ack) begin
                key.req <= 1'b0;   // sink took it
            end else if (single && fresh && !busy) begin
                key.req <= 1'b1;
            end
        end
    end

    // event payload, frozen while req is up
    always_ff @(posedge clk) begin
        if (single && fresh && !busy) begin
            key.op    <= key_op_e'(entry[5:4]);
            key.digit <= entry[3:0];
        end
    end

endmodule

`default_nettype wire

// File: logic/key_if.sv
`timescale 1ns/1ps
`default_nettype none

interface key_if import lock_pkg::*; ();

    logic       req;     // held until ack seen
    key_op_e    op;
    logic [3:0] digit;   // valid for KEY_DIGIT only
    logic       ack;

    modport source (
        output req, op, digit,
        input  ack
    );

    modport sink (
        input  req, op, digit,
        output ack
    );

endinterface

`default_nettype wire

// File: logic/tone_pkg.sv
`default_nettype none

package tone_pkg;

    typedef enum logic [1:0] {
        TONE_CLICK,
        TONE_SUCCESS,
        TONE_FAIL
    } tone_e;

    // all values in tone units
    localparam int CLICK_HALF     = 2;
    localparam int CLICK_LEN      = 40;
    localparam int SUCCESS_HALF   = 1;
    localparam int SUCCESS_LEN    = 120;
    localparam int FAIL_HALF      = 4;
    localparam int FAIL_LEN       = 120;
    localparam int FAIL_GAP_START = 40;
    localparam int FAIL_GAP_END   = 80;   // silent up to here

    function automatic int tone_half(tone_e t);
        return (t == TONE_CLICK) ? CLICK_HALF : (t == TONE_SUCCESS) ? SUCCESS_HALF : FAIL_HALF;
    endfunction

    function automatic int tone_len(tone_e t);
        return (t == TONE_CLICK) ? CLICK_LEN : (t == TONE_SUCCESS) ? SUCCESS_LEN : FAIL_LEN;
    endfunction

endpackage

`default_nettype wire

// File: logic/lock_pkg.sv
`default_nettype none

package lock_pkg;

    typedef enum logic [1:0] {
        KEY_DIGIT,
        KEY_ENTER,
        KEY_CLEAR,
        KEY_RESET
    } key_op_e;

    typedef enum logic [1:0] {
        ST_ENTRY,
        ST_OPEN,
        ST_LOCKED
    } lock_state_e;

    localparam int          CODE_DIGITS   = 3;
    localparam logic [3:0]  BLANK_NIBBLE  = 4'hF;
    localparam logic [11:0] BLANK_DISPLAY = {3{BLANK_NIBBLE}};
    localparam logic [11:0] PASS_PATTERN  = 12'hBCC;   // shown while open

    // one entry per keypad line, {opcode, digit}
    localparam logic [5:0] KEY_MAP [16] = '{
        {KEY_ENTER, 4'hF},   // line 0
        {KEY_DIGIT, 4'd1},
        {KEY_DIGIT, 4'd2},
        {KEY_DIGIT, 4'd0},
        {KEY_DIGIT, 4'd4},
        {KEY_DIGIT, 4'd3},
        {KEY_DIGIT, 4'd2},
        {KEY_DIGIT, 4'd1},
        {KEY_RESET, 4'hF},   // line 8
        {KEY_DIGIT, 4'd6},
        {KEY_DIGIT, 4'd5},
        {KEY_DIGIT, 4'd4},
        {KEY_CLEAR, 4'hF},   // line 12
        {KEY_DIGIT, 4'd9},
        {KEY_DIGIT, 4'd8},
        {KEY_DIGIT, 4'd7}
    };

endpackage

`default_nettype wire
